//--- flist.f
+incdir+.
rv_core_pkg.sv
mem_bus_if.sv
fetch_stage.sv
decoder.sv
register_file.sv
execute_stage.sv
load_store_unit.sv
core_controller.sv
rv_core.sv
rv_core_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the rv_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f flist.f --top-module rv_core_tb -o rv_core_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/rv_core_sim > sim.log 2>&1
status=$?
cat sim.log

if grep -q "RESULT: FAIL" sim.log; then
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi
exit 0

//--- rv_core_tb.sv
/*
 * rv_core directed testbench
 * Instruction and data memory models with random grant delay,
 * instruction encoders, RV32I reference results and store checks
 */

`timescale 1ns/1ps
`include "rv_core_defines.svh"

module rv_core_tb;

  localparam logic [`XLEN-1:0] BOOT_ADDR = 32'h0000_1000;

  logic             clk_i;
  logic             rst_n_i;
  logic [`XLEN-1:0] boot_addr_i;
  logic             fetch_enable_i;
  logic             instr_req_o;
  logic             instr_gnt_i;
  logic             instr_rvalid_i;
  logic [`XLEN-1:0] instr_addr_o;
  logic [`XLEN-1:0] instr_rdata_i;
  logic             data_req_o;
  logic             data_gnt_i;
  logic             data_rvalid_i;
  logic             data_we_o;
  logic [`XLEN-1:0] data_addr_o;
  logic [`XLEN-1:0] data_wdata_o;
  logic [`XLEN-1:0] data_rdata_i;

  // Memories, word indexed by address bits 7:2
  logic [`XLEN-1:0] imem [64];
  logic [`XLEN-1:0] dmem [64];

  // Observed traffic and expected stores
  logic [`XLEN-1:0] fetch_q [$];
  logic [`XLEN-1:0] st_addr_q [$];
  logic [`XLEN-1:0] st_data_q [$];
  logic [`XLEN-1:0] exp_addr_q [$];
  logic [`XLEN-1:0] exp_data_q [$];

  // Bus model state
  logic             i_acc;
  logic             d_acc;
  logic [`XLEN-1:0] i_rdata;
  logic [`XLEN-1:0] d_rdata;
  int               i_cnt;
  int               d_cnt;
  logic             rand_delay;
  logic [31:0]      lcg_state = 32'd93;

  int prog_len;
  int instr_total;
  int cycles;
  int data_accesses;

  rv_core u_rv_core (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .boot_addr_i    (boot_addr_i),
    .fetch_enable_i (fetch_enable_i),
    .instr_req_o    (instr_req_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_addr_o   (instr_addr_o),
    .instr_rdata_i  (instr_rdata_i),
    .data_req_o     (data_req_o),
    .data_gnt_i     (data_gnt_i),
    .data_rvalid_i  (data_rvalid_i),
    .data_we_o      (data_we_o),
    .data_addr_o    (data_addr_o),
    .data_wdata_o   (data_wdata_o),
    .data_rdata_i   (data_rdata_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // Grant delay of 0 to 2 cycles
  function automatic int pick_delay();
    return rand_delay ? int'((lcg_next() >> 16) % 32'd3) : 0;
  endfunction

  function automatic logic [31:0] sext12(input logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  // RV32I arithmetic by funct3, funct7 bit 5 selects SUB
  function automatic logic [31:0] ref_alu(input logic [6:0] f7, input logic [2:0] f3,
                                          input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'd0:    return f7[5] ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd4:    return a ^ b;
      3'd5:    return a >> b[4:0];
      3'd6:    return a | b;
      3'd7:    return a & b;
      default: return 32'd0;
    endcase
  endfunction

  // Instruction encoders
  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [4:0] rs1,
                                        input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] enc_i(input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [4:0] rs1, input logic [11:0] imm);
    return {imm, rs1, f3, rd, 7'b0010011};
  endfunction

  function automatic logic [31:0] enc_lw(input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [11:0] imm);
    return {imm, rs1, 3'b010, rd, 7'b0000011};
  endfunction

  function automatic logic [31:0] enc_sw(input logic [4:0] rs2, input logic [4:0] rs1,
                                         input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] enc_b(input logic [2:0] f3, input logic [4:0] rs1,
                                        input logic [4:0] rs2, input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] enc_j(input logic [4:0] rd, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  function automatic logic [31:0] enc_u(input logic [4:0] rd, input logic [19:0] imm);
    return {imm, rd, 7'b0110111};
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("** Error at %0t: %s is 0x%08h, expected 0x%08h", $time, name, actual,
               expected);
      $display("RESULT: FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Memory bus models
  ////////////////////////////////////////////////////////////
  // One grant decision per bus on each falling edge
  task automatic grant_step(input logic req, inout int cnt, output logic gnt);
    gnt = 1'b0;
    if (req) begin
      if (cnt < 0) begin
        cnt = pick_delay();
      end
      if (cnt == 0) begin
        gnt = 1'b1;
        cnt = -1;
      end else begin
        cnt = cnt - 1;
      end
    end
  endtask

  // Accepted requests, sampled before the DUT updates
  always @(posedge clk_i) begin
    if (rst_n_i && instr_req_o && instr_gnt_i) begin
      fetch_q.push_back(instr_addr_o);
      i_rdata = imem[instr_addr_o[7:2]];
      i_acc   = 1'b1;
    end
    if (rst_n_i && data_req_o && data_gnt_i) begin
      data_accesses = data_accesses + 1;
      d_rdata = dmem[data_addr_o[7:2]];
      d_acc   = 1'b1;
      if (data_we_o) begin
        dmem[data_addr_o[7:2]] = data_wdata_o;
        st_addr_q.push_back(data_addr_o);
        st_data_q.push_back(data_wdata_o);
      end
    end
  end

  // Responses one cycle after grant
  always @(negedge clk_i) begin
    if (!rst_n_i) begin
      instr_gnt_i    = 1'b0;
      instr_rvalid_i = 1'b0;
      data_gnt_i     = 1'b0;
      data_rvalid_i  = 1'b0;
      i_acc          = 1'b0;
      d_acc          = 1'b0;
      i_cnt          = -1;
      d_cnt          = -1;
    end else begin
      instr_rvalid_i = i_acc;
      instr_rdata_i  = i_acc ? i_rdata : '0;
      i_acc          = 1'b0;
      data_rvalid_i  = d_acc;
      data_rdata_i   = d_acc ? d_rdata : '0;
      d_acc          = 1'b0;
      grant_step(instr_req_o, i_cnt, instr_gnt_i);
      grant_step(data_req_o, d_cnt, data_gnt_i);
    end
  end

  // Run limit grows with every program loaded
  always @(posedge clk_i) begin
    if (fetch_enable_i) begin
      cycles = cycles + 1;
    end
    if (cycles > instr_total * 12 + 200) begin
      $display("Timeout: the core did not finish its programs within %0d cycles", cycles);
      $display("RESULT: FAIL");
      $fatal(1, "simulation timed out");
    end
  end

  ////////////////////////////////////////////////////////////
  // Program setup and run
  ////////////////////////////////////////////////////////////
  task automatic begin_program();
    prog_len = 0;
    exp_addr_q.delete();
    exp_data_q.delete();
  endtask

  task automatic emit(input logic [31:0] word);
    imem[prog_len[5:0]] = word;
    prog_len = prog_len + 1;
  endtask

  task automatic expect_store(input logic [31:0] addr, input logic [31:0] data);
    exp_addr_q.push_back(addr);
    exp_data_q.push_back(data);
  endtask

  // Reset, then hold enable low while both buses stay quiet
  task automatic start_core(input int idle_cycles);
    @(negedge clk_i);
    rst_n_i        = 1'b0;
    fetch_enable_i = 1'b0;
    fetch_q.delete();
    st_addr_q.delete();
    st_data_q.delete();
    data_accesses = 0;
    for (int i = 0; i < 64; i++) begin
      dmem[i[5:0]] = ~(32'h200 + i * 4);
    end
    repeat (16) @(negedge clk_i);
    rst_n_i = 1'b1;
    repeat (idle_cycles) begin
      @(negedge clk_i);
      check_value("instr_req_o", {31'b0, instr_req_o}, 32'd0);
      check_value("data_req_o", {31'b0, data_req_o}, 32'd0);
    end
    fetch_enable_i = 1'b1;
  endtask

  task automatic wait_for_traffic(input int n_st, input int n_fetch);
    while (st_data_q.size() < n_st || fetch_q.size() < n_fetch) begin
      @(negedge clk_i);
    end
  endtask

  task automatic compare_stores();
    check_value("store count", st_data_q.size(), exp_data_q.size());
    foreach (exp_data_q[k]) begin
      check_value("data_addr_o", st_addr_q[k], exp_addr_q[k]);
      check_value("data_wdata_o", st_data_q[k], exp_data_q[k]);
    end
  endtask

  task automatic run_program(input int idle_cycles, input int n_fetch);
    instr_total = instr_total + prog_len;
    start_core(idle_cycles);
    wait_for_traffic(exp_data_q.size(), n_fetch);
    compare_stores();
  endtask

  ////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////
  task automatic test_reset();
    begin_program();
    emit(enc_j(5'd0, 21'd0));
    run_program(20, 3);
    for (int k = 0; k < 3; k++) begin
      check_value("instr_addr_o", fetch_q[k], BOOT_ADDR);
    end
    check_value("data accesses", data_accesses, 32'd0);
  endtask

  task automatic test_alu_ops();
    logic [31:0] a;
    logic [31:0] b;
    logic [23:0] r_f3;
    logic [14:0] i_f3;
    logic [59:0] i_imm;
    logic [6:0]  f7;
    logic [11:0] off;
    begin_program();
    // Tables in reverse, entry 0 in the low bits
    r_f3  = {3'd5, 3'd1, 3'd2, 3'd4, 3'd6, 3'd7, 3'd0, 3'd0};
    i_f3  = {3'd2, 3'd4, 3'd6, 3'd7, 3'd0};
    i_imm = {12'h800, 12'hfff, 12'h505, 12'h0f0, 12'hff0};
    a     = {20'h87654, 12'h000} + sext12(12'h321);
    b     = sext12(12'h723);
    off   = 12'h200;
    emit(enc_u(5'd1, 20'h87654));
    emit(enc_i(3'd0, 5'd1, 5'd1, 12'h321));
    emit(enc_i(3'd0, 5'd2, 5'd0, 12'h723));
    for (int k = 0; k < 8; k++) begin
      f7 = (k == 1) ? 7'h20 : 7'h00;
      emit(enc_r(f7, r_f3[k*3 +: 3], 5'd3, 5'd1, 5'd2));
      emit(enc_sw(5'd3, 5'd0, off));
      expect_store({20'h0, off}, ref_alu(f7, r_f3[k*3 +: 3], a, b));
      off = off + 12'd4;
    end
    for (int k = 0; k < 5; k++) begin
      emit(enc_i(i_f3[k*3 +: 3], 5'd3, 5'd1, i_imm[k*12 +: 12]));
      emit(enc_sw(5'd3, 5'd0, off));
      expect_store({20'h0, off}, ref_alu(7'h00, i_f3[k*3 +: 3], a, sext12(i_imm[k*12 +: 12])));
      off = off + 12'd4;
    end
    emit(enc_j(5'd0, 21'd0));
    run_program(4, prog_len);
  endtask

  task automatic test_load_use();
    begin_program();
    emit(enc_u(5'd1, 20'h12345));
    emit(enc_i(3'd0, 5'd1, 5'd1, 12'h678));
    emit(enc_sw(5'd1, 5'd0, 12'h210));
    emit(enc_lw(5'd2, 5'd0, 12'h210));
    emit(enc_i(3'd0, 5'd3, 5'd2, 12'h011));
    emit(enc_sw(5'd3, 5'd0, 12'h214));
    emit(enc_j(5'd0, 21'd0));
    expect_store(32'h210, 32'h1234_5678);
    expect_store(32'h214, 32'h1234_5678 + 32'h11);
    run_program(4, 7);
  endtask

  task automatic test_control_flow();
    logic [63:0] offs;
    begin_program();
    offs = {8'h24, 8'h20, 8'h18, 8'h14, 8'h10, 8'h08, 8'h04, 8'h00};
    emit(enc_i(3'd0, 5'd1, 5'd0, 12'h005));
    emit(enc_i(3'd0, 5'd2, 5'd0, 12'h005));
    // Taken BEQ over a store, then a BNE that falls through
    emit(enc_b(3'b000, 5'd1, 5'd2, 13'd8));
    emit(enc_sw(5'd1, 5'd0, 12'h200));
    emit(enc_b(3'b001, 5'd1, 5'd2, 13'd8));
    emit(enc_sw(5'd2, 5'd0, 12'h204));
    emit(enc_j(5'd3, 21'd8));
    emit(enc_sw(5'd1, 5'd0, 12'h208));
    emit(enc_sw(5'd3, 5'd0, 12'h20c));
    emit(enc_j(5'd0, 21'd0));
    expect_store(32'h204, 32'd5);
    // Link value of the JAL at word 6
    expect_store(32'h20c, BOOT_ADDR + 32'd28);
    run_program(4, 8);
    for (int k = 0; k < 8; k++) begin
      check_value("instr_addr_o", fetch_q[k], BOOT_ADDR + {24'b0, offs[k*8 +: 8]});
    end
  endtask

  task automatic test_x0_nop();
    begin_program();
    emit(enc_i(3'd0, 5'd5, 5'd0, 12'h123));
    emit(enc_i(3'd0, 5'd0, 5'd0, 12'h077));
    // MUL and AUIPC, both outside the subset
    emit(enc_r(7'h01, 3'd0, 5'd5, 5'd5, 5'd5));
    emit({20'h12345, 5'd5, 7'b0010111});
    emit(enc_sw(5'd0, 5'd0, 12'h220));
    emit(enc_sw(5'd5, 5'd0, 12'h224));
    emit(enc_j(5'd0, 21'd0));
    expect_store(32'h220, 32'd0);
    expect_store(32'h224, 32'h123);
    run_program(4, 7);
    check_value("data accesses", data_accesses, 32'd2);
  endtask

  initial begin
    rst_n_i        = 1'b0;
    fetch_enable_i = 1'b0;
    boot_addr_i    = BOOT_ADDR;
    instr_gnt_i    = 1'b0;
    instr_rvalid_i = 1'b0;
    instr_rdata_i  = '0;
    data_gnt_i     = 1'b0;
    data_rvalid_i  = 1'b0;
    data_rdata_i   = '0;
    i_acc          = 1'b0;
    d_acc          = 1'b0;
    i_cnt          = -1;
    d_cnt          = -1;
    instr_total    = 0;
    cycles         = 0;
    data_accesses  = 0;
    rand_delay     = 1'b0;
    test_reset();
    test_alu_ops();
    test_load_use();
    test_control_flow();
    test_x0_nop();
    // Same programs under random grant delay
    rand_delay = 1'b1;
    test_alu_ops();
    test_load_use();
    test_control_flow();
    $display("RESULT: PASS");
    $finish;
  end

endmodule

//--- rv_core.sv
/*
 * rv_core top level
 * Multi-cycle RV32I subset core with separate instruction and data buses
 */

`timescale 1ns/1ps
`include "rv_core_defines.svh"

module rv_core (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic [`XLEN-1:0] boot_addr_i,
  input  logic             fetch_enable_i,
  // Instruction bus
  output logic             instr_req_o,
  input  logic             instr_gnt_i,
  input  logic             instr_rvalid_i,
  output logic [`XLEN-1:0] instr_addr_o,
  input  logic [`XLEN-1:0] instr_rdata_i,
  // Data bus
  output logic             data_req_o,
  input  logic             data_gnt_i,
  input  logic             data_rvalid_i,
  output logic             data_we_o,
  output logic [`XLEN-1:0] data_addr_o,
  output logic [`XLEN-1:0] data_wdata_o,
  input  logic [`XLEN-1:0] data_rdata_i
);

  import rv_core_pkg::*;

  mem_bus_if instr_bus ();
  mem_bus_if data_bus ();

  decode_t          dec;
  logic [`XLEN-1:0] pc;
  logic [`XLEN-1:0] pc_next;
  logic [`XLEN-1:0] instr;
  logic [`XLEN-1:0] rs1_data;
  logic [`XLEN-1:0] rs2_data;
  logic [`XLEN-1:0] alu_result;
  logic [`XLEN-1:0] lsu_rdata;
  logic [`XLEN-1:0] rf_wdata;
  logic             instr_valid;
  logic             fetch_start;
  logic             mem_start;
  logic             pc_update;
  logic             rf_we;
  logic             lsu_done;

  ////////////////////////////////////////////////////////////
  // Bus port mapping
  ////////////////////////////////////////////////////////////
  // Instruction bus is read-only, we and wdata stay inside
  assign instr_req_o      = instr_bus.req;
  assign instr_addr_o     = instr_bus.addr;
  assign instr_bus.gnt    = instr_gnt_i;
  assign instr_bus.rvalid = instr_rvalid_i;
  assign instr_bus.rdata  = instr_rdata_i;

  assign data_req_o      = data_bus.req;
  assign data_we_o       = data_bus.we;
  assign data_addr_o     = data_bus.addr;
  assign data_wdata_o    = data_bus.wdata;
  assign data_bus.gnt    = data_gnt_i;
  assign data_bus.rvalid = data_rvalid_i;
  assign data_bus.rdata  = data_rdata_i;

  ////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////
  fetch_stage u_fetch_stage (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .boot_addr_i   (boot_addr_i),
    .fetch_start_i (fetch_start),
    .pc_update_i   (pc_update),
    .pc_next_i     (pc_next),
    .bus_o         (instr_bus.manager),
    .pc_o          (pc),
    .instr_o       (instr),
    .instr_valid_o (instr_valid)
  );

  decoder u_decoder (
    .instr_i (instr),
    .dec_o   (dec)
  );

  register_file u_register_file (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .raddr_a_i (dec.rs1),
    .raddr_b_i (dec.rs2),
    .rdata_a_o (rs1_data),
    .rdata_b_o (rs2_data),
    .we_i      (rf_we),
    .waddr_i   (dec.rd),
    .wdata_i   (rf_wdata)
  );

  execute_stage u_execute_stage (
    .dec_i     (dec),
    .pc_i      (pc),
    .rs1_i     (rs1_data),
    .rs2_i     (rs2_data),
    .result_o  (alu_result),
    .pc_next_o (pc_next)
  );

  // Address is the ALU sum, store data is rs2
  load_store_unit u_load_store_unit (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .mem_start_i (mem_start),
    .dec_i       (dec),
    .addr_i      (alu_result),
    .wdata_i     (rs2_data),
    .bus_o       (data_bus.manager),
    .lsu_rdata_o (lsu_rdata),
    .lsu_done_o  (lsu_done)
  );

  ////////////////////////////////////////////////////////////
  // Control
  ////////////////////////////////////////////////////////////
  core_controller u_core_controller (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .fetch_enable_i (fetch_enable_i),
    .instr_valid_i  (instr_valid),
    .dec_i          (dec),
    .alu_result_i   (alu_result),
    .lsu_rdata_i    (lsu_rdata),
    .lsu_done_i     (lsu_done),
    .fetch_start_o  (fetch_start),
    .mem_start_o    (mem_start),
    .pc_update_o    (pc_update),
    .rf_we_o        (rf_we),
    .rf_wdata_o     (rf_wdata)
  );

endmodule

//--- core_controller.sv
/*
 * Core controller
 * IDLE/FETCH/EXECUTE/MEMORY sequencing and register writeback
 */

`timescale 1ns/1ps
`include "rv_core_defines.svh"

module core_controller (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 fetch_enable_i,
  input  logic                 instr_valid_i,
  input  rv_core_pkg::decode_t dec_i,
  input  logic [`XLEN-1:0]     alu_result_i,
  input  logic [`XLEN-1:0]     lsu_rdata_i,
  input  logic                 lsu_done_i,
  output logic                 fetch_start_o,
  output logic                 mem_start_o,
  output logic                 pc_update_o,
  output logic                 rf_we_o,
  output logic [`XLEN-1:0]     rf_wdata_o
);

  import rv_core_pkg::*;

  ctrl_state_e state_q;
  ctrl_state_e state_d;
  logic        is_mem;
  logic        exec;
  logic        mem_done;

  assign is_mem   = dec_i.is_load || dec_i.is_store;
  assign exec     = state_q == ST_EXECUTE;
  assign mem_done = state_q == ST_MEMORY && lsu_done_i;

  ////////////////////////////////////////////////////////////
  // State sequencing
  ////////////////////////////////////////////////////////////
  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE:    if (fetch_enable_i) state_d = ST_FETCH;
      ST_FETCH:   if (instr_valid_i) state_d = ST_EXECUTE;
      // Single cycle, memory ops move on to the LSU
      ST_EXECUTE: state_d = is_mem ? ST_MEMORY : ST_FETCH;
      ST_MEMORY:  if (lsu_done_i) state_d = ST_FETCH;
      default:    state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  ////////////////////////////////////////////////////////////
  // Strobes to fetch and LSU
  ////////////////////////////////////////////////////////////
  // Instruction retires at end of EXECUTE or on LSU done
  assign pc_update_o   = (exec && !is_mem) || mem_done;
  // Next fetch launched with the PC update
  assign fetch_start_o = pc_update_o || (state_q == ST_IDLE && fetch_enable_i);
  assign mem_start_o   = exec && is_mem;

  // Writeback, loads only once their data returns
  assign rf_we_o    = dec_i.rf_we && ((exec && !dec_i.is_load) || (mem_done && dec_i.is_load));
  assign rf_wdata_o = dec_i.is_load ? lsu_rdata_i : alu_result_i;

  // Completions only arrive in the state that waits for them
  a_fetch_resp_state: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    instr_valid_i |-> state_q == ST_FETCH);

  a_lsu_resp_state: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    lsu_done_i |-> state_q == ST_MEMORY);

endmodule

//--- load_store_unit.sv
/*
 * Load/store unit
 * Word loads and stores, one data bus transfer per start pulse
 */

`timescale 1ns/1ps
`include "rv_core_defines.svh"

module load_store_unit (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 mem_start_i,
  input  rv_core_pkg::decode_t dec_i,
  input  logic [`XLEN-1:0]     addr_i,
  input  logic [`XLEN-1:0]     wdata_i,
  mem_bus_if.manager           bus_o,
  output logic [`XLEN-1:0]     lsu_rdata_o,
  output logic                 lsu_done_o
);

  logic [`XLEN-1:0] addr_q;
  logic [`XLEN-1:0] wdata_q;
  logic             we_q;
  logic             req_q;
  logic             wait_q;

  // Request payload latched at start
  always_ff @(posedge clk_i) begin
    if (mem_start_i) begin
      addr_q  <= addr_i;
      wdata_q <= wdata_i;
      we_q    <= dec_i.is_store;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      req_q  <= 1'b0;
      wait_q <= 1'b0;
    end else begin
      if (mem_start_i) begin
        req_q <= 1'b1;
      end else if (req_q && bus_o.gnt) begin
        req_q <= 1'b0;
      end
      if (req_q && bus_o.gnt) begin
        wait_q <= 1'b1;
      end else if (bus_o.rvalid) begin
        wait_q <= 1'b0;
      end
    end
  end

  assign bus_o.req   = req_q;
  assign bus_o.we    = we_q;
  assign bus_o.addr  = addr_q;
  assign bus_o.wdata = wdata_q;

  // Load data straight to writeback in the rvalid cycle
  assign lsu_done_o  = wait_q && bus_o.rvalid;
  assign lsu_rdata_o = bus_o.rdata;

  // Controller must not start a transfer while one is in flight
  a_one_outstanding: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wait_q |-> !bus_o.req && !mem_start_i);

endmodule

//--- execute_stage.sv
/*
 * Execute stage
 * ALU, BEQ/BNE compare and next PC select
 */

`timescale 1ns/1ps
`include "rv_core_defines.svh"

module execute_stage (
  input  rv_core_pkg::decode_t dec_i,
  input  logic [`XLEN-1:0]     pc_i,
  input  logic [`XLEN-1:0]     rs1_i,
  input  logic [`XLEN-1:0]     rs2_i,
  output logic [`XLEN-1:0]     result_o,
  output logic [`XLEN-1:0]     pc_next_o
);

  import rv_core_pkg::*;

  logic [`XLEN-1:0] op_b;
  logic [`XLEN-1:0] alu_res;
  logic [`XLEN-1:0] pc_plus4;
  logic             taken;

  // Second operand from register or immediate
  assign op_b = dec_i.use_imm ? dec_i.imm : rs2_i;

  always_comb begin
    case (dec_i.alu_op)
      ALU_SUB:    alu_res = rs1_i - op_b;
      ALU_AND:    alu_res = rs1_i & op_b;
      ALU_OR:     alu_res = rs1_i | op_b;
      ALU_XOR:    alu_res = rs1_i ^ op_b;
      ALU_SLT:    alu_res = {{(`XLEN-1){1'b0}}, $signed(rs1_i) < $signed(op_b)};
      // Shift amount is the low 5 bits
      ALU_SLL:    alu_res = rs1_i << op_b[4:0];
      ALU_SRL:    alu_res = rs1_i >> op_b[4:0];
      ALU_PASS_B: alu_res = op_b;
      default:    alu_res = rs1_i + op_b;
    endcase
  end

  assign pc_plus4 = pc_i + `XLEN'd4;

  // Link value for JAL
  assign result_o = dec_i.is_jal ? pc_plus4 : alu_res;

  // BNE inverts the equality
  assign taken = dec_i.is_branch && ((rs1_i == rs2_i) ^ dec_i.branch_ne);

  assign pc_next_o = (dec_i.is_jal || taken) ? pc_i + dec_i.imm : pc_plus4;

endmodule

//--- register_file.sv
/*
 * Integer register file
 * Two combinational read ports and one write port, x0 hard zero
 */

`timescale 1ns/1ps
`include "rv_core_defines.svh"

module register_file (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic [`RF_ADDR_W-1:0] raddr_a_i,
  input  logic [`RF_ADDR_W-1:0] raddr_b_i,
  output logic [`XLEN-1:0]      rdata_a_o,
  output logic [`XLEN-1:0]      rdata_b_o,
  input  logic                  we_i,
  input  logic [`RF_ADDR_W-1:0] waddr_i,
  input  logic [`XLEN-1:0]      wdata_i
);

  logic [`XLEN-1:0] regs_q [`RF_DEPTH];

  // Writes to x0 dropped
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < `RF_DEPTH; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && waddr_i != '0) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

//--- decoder.sv
/*
 * Instruction decoder
 * Maps the supported RV32I subset to control flags and an immediate,
 * anything else decodes as a NOP
 */

`timescale 1ns/1ps
`include "rv_core_defines.svh"

module decoder (
  input  logic [`XLEN-1:0]  instr_i,
  output rv_core_pkg::decode_t dec_o
);

  import rv_core_pkg::*;

  opcode_e          opcode;
  logic [2:0]       funct3;
  logic [6:0]       funct7;
  logic [`XLEN-1:0] imm_i;
  logic [`XLEN-1:0] imm_s;
  logic [`XLEN-1:0] imm_b;
  logic [`XLEN-1:0] imm_j;
  logic [`XLEN-1:0] imm_u;

  assign opcode = opcode_e'(instr_i[6:0]);
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  ////////////////////////////////////////////////////////////
  // Immediates, sign extended from bit 31
  ////////////////////////////////////////////////////////////
  assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                  instr_i[11:8], 1'b0};
  assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                  instr_i[30:21], 1'b0};
  assign imm_u = {instr_i[31:12], 12'b0};

  ////////////////////////////////////////////////////////////
  // Control decode
  ////////////////////////////////////////////////////////////
  always_comb begin
    // All flags low by default, which is the NOP
    dec_o     = '0;
    dec_o.rs1 = instr_i[19:15];
    dec_o.rs2 = instr_i[24:20];
    dec_o.rd  = instr_i[11:7];
    case (opcode)
      OPC_OP: begin
        dec_o.rf_we = 1'b1;
        case ({funct7, funct3})
          {7'h00, 3'b000}: dec_o.alu_op = ALU_ADD;
          {7'h20, 3'b000}: dec_o.alu_op = ALU_SUB;
          {7'h00, 3'b111}: dec_o.alu_op = ALU_AND;
          {7'h00, 3'b110}: dec_o.alu_op = ALU_OR;
          {7'h00, 3'b100}: dec_o.alu_op = ALU_XOR;
          {7'h00, 3'b010}: dec_o.alu_op = ALU_SLT;
          {7'h00, 3'b001}: dec_o.alu_op = ALU_SLL;
          {7'h00, 3'b101}: dec_o.alu_op = ALU_SRL;
          default:         dec_o.rf_we  = 1'b0;
        endcase
      end
      OPC_OP_IMM: begin
        dec_o.rf_we   = 1'b1;
        dec_o.use_imm = 1'b1;
        dec_o.imm     = imm_i;
        case (funct3)
          3'b000:  dec_o.alu_op = ALU_ADD;
          3'b111:  dec_o.alu_op = ALU_AND;
          3'b110:  dec_o.alu_op = ALU_OR;
          3'b100:  dec_o.alu_op = ALU_XOR;
          3'b010:  dec_o.alu_op = ALU_SLT;
          default: dec_o.rf_we  = 1'b0;
        endcase
      end
      OPC_LUI: begin
        dec_o.rf_we   = 1'b1;
        dec_o.use_imm = 1'b1;
        dec_o.imm     = imm_u;
        dec_o.alu_op  = ALU_PASS_B;
      end
      OPC_LOAD: begin
        // Word loads only; address is rs1 plus offset
        dec_o.use_imm = 1'b1;
        dec_o.imm     = imm_i;
        dec_o.is_load = funct3 == 3'b010;
        dec_o.rf_we   = funct3 == 3'b010;
      end
      OPC_STORE: begin
        dec_o.use_imm  = 1'b1;
        dec_o.imm      = imm_s;
        dec_o.is_store = funct3 == 3'b010;
      end
      OPC_BRANCH: begin
        // BEQ and BNE only
        dec_o.imm       = imm_b;
        dec_o.is_branch = funct3[2:1] == 2'b00;
        dec_o.branch_ne = funct3[0];
      end
      OPC_JAL: begin
        dec_o.imm    = imm_j;
        dec_o.rf_we  = 1'b1;
        dec_o.is_jal = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

//--- fetch_stage.sv
/*
 * Instruction fetch
 * Holds the PC and runs one instruction bus read per start pulse
 */

`timescale 1ns/1ps
`include "rv_core_defines.svh"

module fetch_stage (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic [`XLEN-1:0] boot_addr_i,
  input  logic             fetch_start_i,
  input  logic             pc_update_i,
  input  logic [`XLEN-1:0] pc_next_i,
  mem_bus_if.manager       bus_o,
  output logic [`XLEN-1:0] pc_o,
  output logic [`XLEN-1:0] instr_o,
  output logic             instr_valid_o
);

  logic [`XLEN-1:0] pc_q;
  logic [`XLEN-1:0] instr_q;
  logic             booted_q;
  logic             req_q;
  logic             wait_q;

  // PC tracks boot address until the first fetch starts
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pc_q     <= '0;
      booted_q <= 1'b0;
    end else if (!booted_q) begin
      pc_q     <= boot_addr_i;
      booted_q <= fetch_start_i;
    end else if (pc_update_i) begin
      pc_q <= pc_next_i;
    end
  end

  // Request until granted, then wait for rvalid
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      req_q  <= 1'b0;
      wait_q <= 1'b0;
    end else begin
      if (fetch_start_i) begin
        req_q <= 1'b1;
      end else if (req_q && bus_o.gnt) begin
        req_q <= 1'b0;
      end
      if (req_q && bus_o.gnt) begin
        wait_q <= 1'b1;
      end else if (bus_o.rvalid) begin
        wait_q <= 1'b0;
      end
    end
  end

  assign instr_valid_o = wait_q && bus_o.rvalid;

  // Instruction word held for decode
  always_ff @(posedge clk_i) begin
    if (instr_valid_o) begin
      instr_q <= bus_o.rdata;
    end
  end

  // Read-only port
  assign bus_o.req   = req_q;
  assign bus_o.we    = 1'b0;
  assign bus_o.addr  = pc_q;
  assign bus_o.wdata = '0;

  assign pc_o    = pc_q;
  assign instr_o = instr_q;

  // Request held stable under back-pressure
  a_addr_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    bus_o.req && !bus_o.gnt |=> $stable(bus_o.addr));

  a_pc_aligned: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    booted_q |-> pc_q[1:0] == 2'b00);

endmodule

//--- mem_bus_if.sv
/*
 * Request/grant/response-valid memory bus
 * One request outstanding; gnt accepts, rvalid returns
 */

`timescale 1ns/1ps
`include "rv_core_defines.svh"

interface mem_bus_if;

  // Request side
  logic             req;
  logic             we;
  logic [`XLEN-1:0] addr;
  logic [`XLEN-1:0] wdata;

  // Response side
  logic             gnt;
  logic             rvalid;
  logic [`XLEN-1:0] rdata;

  modport manager (output req, we, addr, wdata, input gnt, rvalid, rdata);
  modport subordinate (input req, we, addr, wdata, output gnt, rvalid, rdata);

endinterface

//--- rv_core_pkg.sv
/*
 * rv_core package
 * Opcode, ALU operation and controller state encodings,
 * plus the decoded instruction bundle
 */

`include "rv_core_defines.svh"

package rv_core_pkg;

  // Major opcodes in use, RV32I base encoding
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111
  } opcode_e;

  // ALU functions
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
    ALU_SLT, ALU_SLL, ALU_SRL, ALU_PASS_B
  } alu_op_e;

  // Instruction sequencing states
  typedef enum logic [1:0] {
    ST_IDLE, ST_FETCH, ST_EXECUTE, ST_MEMORY
  } ctrl_state_e;

  // Decoded instruction
  typedef struct packed {
    logic [`RF_ADDR_W-1:0] rs1;
    logic [`RF_ADDR_W-1:0] rs2;
    logic [`RF_ADDR_W-1:0] rd;
    logic [`XLEN-1:0]      imm;
    alu_op_e               alu_op;
    logic                  use_imm;
    logic                  rf_we;
    logic                  is_load;
    logic                  is_store;
    logic                  is_branch;
    logic                  branch_ne;
    logic                  is_jal;
  } decode_t;

endpackage

//--- rv_core_defines.svh
/*
 * rv_core width and size macros
 * Shared by the package, the bus interface and all core modules
 */

`ifndef RV_CORE_DEFINES_SVH
`define RV_CORE_DEFINES_SVH

// Data word and bus address width
`define XLEN 32

// Architectural integer registers
`define RF_DEPTH 32

// Register index width, log2 of RF_DEPTH
`define RF_ADDR_W 5

`endif
